/* Makefile */
VERILATOR  ?= verilator
TOP        := glay_kernel_setup_tb
FILELIST   := glay_kernel_setup.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
PASS_MSG   := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fxq '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* glay_kernel_setup.f */
hdl/kernel_setup_pkg.sv
hdl/read_engine_if.sv
hdl/serial_read_engine.sv
hdl/setup_fsm.sv
hdl/sync_fifo.sv
hdl/glay_kernel_setup.sv
verification/tb_clock_gen.sv
verification/glay_kernel_setup_tb.sv

/* hdl/glay_kernel_setup.sv */
// GLay kernel setup top level

`timescale 1ns/1ns

module glay_kernel_setup (
    input  logic                     ap_clk,
    input  logic                     setup_areset,
    input  logic                     descriptor_valid,
    input  kernel_setup_pkg::addr_t  descriptor_pointer,
    input  kernel_setup_pkg::count_t descriptor_count,
    output logic                     mem_req_valid,
    output kernel_setup_pkg::addr_t  mem_req_addr,
    input  logic                     mem_req_rd_en,
    input  logic                     mem_resp_in_valid,
    input  kernel_setup_pkg::resp_t  mem_resp_in_data,
    output logic                     mem_resp_valid,
    output kernel_setup_pkg::resp_t  mem_resp_data,
    input  logic                     mem_resp_rd_en,
    output logic                     setup_done
);
    import kernel_setup_pkg::*;

    logic   desc_valid_q;
    addr_t  desc_pointer_q;
    count_t desc_count_q;
    logic   resp_valid_q;
    resp_t  resp_data_q;
    logic   req_almost_full;

    read_engine_if engine_bus ();

    // --------------------
    // Input registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            desc_valid_q <= 1'b0;
            resp_valid_q <= 1'b0;
        end else begin
            desc_valid_q <= descriptor_valid;
            resp_valid_q <= mem_resp_in_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        desc_pointer_q <= descriptor_pointer;
        desc_count_q   <= descriptor_count;
        resp_data_q    <= mem_resp_in_data;
    end

    // --------------------
    // Sequencing
    // --------------------
    setup_fsm setup_fsm_i (
        .ap_clk             (ap_clk),
        .setup_areset       (setup_areset),
        .descriptor_valid   (desc_valid_q),
        .descriptor_pointer (desc_pointer_q),
        .descriptor_count   (desc_count_q),
        .req_almost_full    (req_almost_full),
        .engine             (engine_bus.control),
        .setup_done         (setup_done)
    );

    serial_read_engine serial_read_engine_i (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .engine       (engine_bus.engine)
    );

    // --------------------
    // FIFOs
    // --------------------

    // Every engine pop lands one address in the request FIFO
    sync_fifo #(
        .WIDTH       (ADDR_WIDTH),
        .DEPTH       (REQ_FIFO_DEPTH),
        .ALMOST_FULL (REQ_ALMOST_FULL)
    ) req_fifo_i (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .wr_en        (engine_bus.pop),
        .din          (engine_bus.req_addr),
        .rd_en        (mem_req_rd_en),
        .dout         (mem_req_addr),
        .valid        (mem_req_valid),
        .full         (),
        .almost_full  (req_almost_full)
    );

    // No back-pressure toward memory, the outstanding limit is external
    sync_fifo #(
        .WIDTH       (RESP_WIDTH),
        .DEPTH       (RESP_FIFO_DEPTH),
        .ALMOST_FULL (RESP_FIFO_DEPTH)
    ) resp_fifo_i (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .wr_en        (resp_valid_q),
        .din          (resp_data_q),
        .rd_en        (mem_resp_rd_en),
        .dout         (mem_resp_data),
        .valid        (mem_resp_valid),
        .full         (),
        .almost_full  ()
    );

endmodule : glay_kernel_setup

/* hdl/kernel_setup_pkg.sv */
// Kernel setup shared definitions

package kernel_setup_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int ADDR_WIDTH  = 64;
    localparam int COUNT_WIDTH = 32;
    localparam int RESP_WIDTH  = 64;

    // Address step between two consecutive read requests
    localparam int CACHELINE_BYTES = 64;

    // --------------------
    // FIFO sizing
    // --------------------
    localparam int REQ_FIFO_DEPTH  = 32;
    localparam int RESP_FIFO_DEPTH = 32;

    // Leaves headroom for the pops already in flight
    localparam int REQ_ALMOST_FULL = 28;

    // --------------------
    // Types
    // --------------------
    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;
    typedef logic [RESP_WIDTH-1:0]  resp_t;

    // Setup FSM states
    typedef enum logic [2:0] {
        SETUP_RESET,
        SETUP_IDLE,
        SETUP_REQ_START,
        SETUP_REQ_BUSY,
        SETUP_REQ_DONE
    } setup_state_t;

endpackage : kernel_setup_pkg

/* hdl/read_engine_if.sv */
// Read engine control interface

`timescale 1ns/1ns

interface read_engine_if;
    import kernel_setup_pkg::*;

    // Job configuration and flow control from the FSM
    logic   start;
    addr_t  array_pointer;
    count_t array_size;
    logic   pop;

    // Engine status and current address
    logic   ready;
    logic   done;
    logic   req_valid;
    addr_t  req_addr;

    modport control (
        output start, array_pointer, array_size, pop,
        input  ready, done, req_valid, req_addr
    );

    modport engine (
        input  start, array_pointer, array_size, pop,
        output ready, done, req_valid, req_addr
    );

endinterface : read_engine_if

/* hdl/serial_read_engine.sv */
// Serial cache-line read engine

`timescale 1ns/1ns

module serial_read_engine (
    input  logic          ap_clk,
    input  logic          setup_areset,
    read_engine_if.engine engine
);
    import kernel_setup_pkg::*;

    // Address of the next cache line to hand out
    addr_t  next_addr;

    // Cache lines still to be handed out
    count_t remaining;

    logic   idle;
    logic   accept;

    // --------------------
    // Status
    // --------------------
    assign idle   = (remaining == '0);
    assign accept = engine.start && idle;

    // A finished engine is also ready for the next job
    assign engine.ready     = idle;
    assign engine.done      = idle;
    assign engine.req_valid = !idle;
    assign engine.req_addr  = next_addr;

    // --------------------
    // Remaining count
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            remaining <= '0;
        end else if (accept) begin
            remaining <= engine.array_size;
        end else if (engine.pop) begin
            remaining <= remaining - count_t'(1);
        end
    end

    // --------------------
    // Address generation
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            next_addr <= engine.array_pointer;
        end else if (engine.pop) begin
            next_addr <= next_addr + addr_t'(CACHELINE_BYTES);
        end
    end

    // --------------------
    // Checks
    // --------------------

    // The FSM may only consume an address that is there
    property pop_needs_address;
        @(posedge ap_clk) disable iff (setup_areset)
        engine.pop |-> engine.req_valid;
    endproperty
    assert property (pop_needs_address)
        else $error("serial_read_engine: pop without a valid address");

endmodule : serial_read_engine

/* hdl/setup_fsm.sv */
// Kernel setup state machine

`timescale 1ns/1ns

module setup_fsm (
    input  logic                     ap_clk,
    input  logic                     setup_areset,
    input  logic                     descriptor_valid,
    input  kernel_setup_pkg::addr_t  descriptor_pointer,
    input  kernel_setup_pkg::count_t descriptor_count,
    input  logic                     req_almost_full,
    read_engine_if.control           engine,
    output logic                     setup_done
);
    import kernel_setup_pkg::*;

    setup_state_t state;
    setup_state_t next_state;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            state <= SETUP_RESET;
        end else begin
            state <= next_state;
        end
    end

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            SETUP_RESET: begin
                next_state = SETUP_IDLE;
            end
            SETUP_IDLE: begin
                if (descriptor_valid && engine.ready) begin
                    next_state = SETUP_REQ_START;
                end
            end
            SETUP_REQ_START: begin
                next_state = SETUP_REQ_BUSY;
            end
            SETUP_REQ_BUSY: begin
                // Engine empty means every address is already in the FIFO
                if (engine.done) begin
                    next_state = SETUP_REQ_DONE;
                end
            end
            SETUP_REQ_DONE: begin
                if (!descriptor_valid) begin
                    next_state = SETUP_IDLE;
                end
            end
            default: begin
                next_state = SETUP_IDLE;
            end
        endcase
    end

    // --------------------
    // Outputs
    // --------------------
    assign engine.start         = (state == SETUP_REQ_START);
    assign engine.array_pointer = descriptor_pointer;
    assign engine.array_size    = descriptor_count;

    // Move one address per cycle while the request FIFO has room
    assign engine.pop = (state == SETUP_REQ_BUSY) && engine.req_valid && !req_almost_full;

    assign setup_done = (state == SETUP_REQ_DONE);

endmodule : setup_fsm

/* hdl/sync_fifo.sv */
// Synchronous show-ahead FIFO

`timescale 1ns/1ns

module sync_fifo #(
    parameter int WIDTH       = 64,
    parameter int DEPTH       = 32,
    parameter int ALMOST_FULL = 28
) (
    input  logic             ap_clk,
    input  logic             setup_areset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    output logic             full,
    output logic             almost_full
);
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;

    // --------------------
    // Pointers and fill level
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_WIDTH'(wr_en) - CNT_WIDTH'(rd_en);
        end
    end

    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // Head entry shown ahead of the pop
    assign dout        = mem[rd_ptr];
    assign valid       = (count != '0);
    assign full        = (count == CNT_WIDTH'(DEPTH));
    assign almost_full = (count >= CNT_WIDTH'(ALMOST_FULL));

    assert property (@(posedge ap_clk) disable iff (setup_areset) wr_en |-> !full)
        else $error("sync_fifo: write while full");
    assert property (@(posedge ap_clk) disable iff (setup_areset) rd_en |-> valid)
        else $error("sync_fifo: read while empty");

endmodule : sync_fifo

/* verification/glay_kernel_setup_tb.sv */
// GLay kernel setup testbench

`timescale 1ns/1ns

module glay_kernel_setup_tb;
    import kernel_setup_pkg::*;

    localparam logic [31:0] SEED = 32'hd806_7d55;

    // Job sizes and the watchdog limit
    localparam int JOB1_COUNT = 10;
    localparam int JOB2_COUNT = 100;
    localparam int JOB3_COUNT = 12;
    localparam int RESP_COUNT = 20;
    localparam int TIMEOUT_CYCLES =
        (JOB1_COUNT + JOB2_COUNT + JOB3_COUNT + RESP_COUNT) * 20 + 1000;

    logic   ap_clk;
    logic   setup_areset;
    logic   descriptor_valid;
    addr_t  descriptor_pointer;
    count_t descriptor_count;
    logic   mem_req_valid;
    addr_t  mem_req_addr;
    logic   mem_req_rd_en;
    logic   mem_resp_in_valid;
    resp_t  mem_resp_in_data;
    logic   mem_resp_valid;
    resp_t  mem_resp_data;
    logic   mem_resp_rd_en;
    logic   setup_done;

    // Scoreboard state
    addr_t       job_pointer;
    int          job_count;
    int          req_base;
    int          req_seen;
    int          resp_seen;
    resp_t       resp_queue[$];
    logic        req_random;
    logic        resp_random;
    logic [31:0] pop_state;
    logic [31:0] data_state;
    int          checks;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_start_errors;

    tb_clock_gen clock_gen_i (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset)
    );

    glay_kernel_setup dut_i (.*);

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Address of the i-th request of a job
    function automatic addr_t expected_req_addr(input addr_t pointer, input int index);
        return pointer + addr_t'(index) * addr_t'(64);
    endfunction

    // Oldest response still owed by the DUT
    function automatic resp_t expected_resp();
        return resp_queue.pop_front();
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error at t=%0t: %s", $time, msg);
    endtask

    // --------------------
    // Compare process
    // --------------------

    // A pop seen mid-cycle takes effect at the next rising edge
    initial begin
        req_seen  = 0;
        resp_seen = 0;
        forever begin
            @(negedge ap_clk);
            if (mem_req_valid === 1'b1 && mem_req_rd_en === 1'b1) begin
                if (req_seen - req_base >= job_count) begin
                    report_error("request popped beyond the end of the job");
                end else begin
                    compare_value("mem_req_addr", mem_req_addr,
                                  expected_req_addr(job_pointer, req_seen - req_base));
                end
                req_seen++;
            end
            if (mem_resp_valid === 1'b1 && mem_resp_rd_en === 1'b1) begin
                if (resp_queue.size() == 0) begin
                    report_error("response popped with none outstanding");
                end else begin
                    compare_value("mem_resp_data", mem_resp_data, expected_resp());
                end
                resp_seen++;
            end
        end
    end

    // Pop driver for both FIFO read sides
    initial begin
        mem_req_rd_en  = 1'b0;
        mem_resp_rd_en = 1'b0;
        pop_state      = SEED;
        forever begin
            @(posedge ap_clk);
            #1;
            pop_state      = xorshift32(pop_state);
            // Random request pops at about one in four
            mem_req_rd_en  = (mem_req_valid === 1'b1) &&
                             (!req_random || pop_state[1:0] == 2'b00);
            mem_resp_rd_en = (mem_resp_valid === 1'b1) && (!resp_random || pop_state[8]);
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge ap_clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // --------------------
    // Stimulus
    // --------------------
    task automatic wait_cycle();
        @(posedge ap_clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // Present one descriptor and follow it through done and release
    task automatic run_job(input addr_t pointer, input int count, input logic random_pops);
        int hold;
        job_pointer        = pointer;
        job_count          = count;
        req_base           = req_seen;
        req_random         = random_pops;
        descriptor_pointer = pointer;
        descriptor_count   = count_t'(count);
        descriptor_valid   = 1'b1;
        while (!(setup_done === 1'b1 && req_seen - req_base == count)) begin
            wait_cycle();
        end
        // Done holds while the descriptor stays up and nothing more arrives
        for (hold = 0; hold < 6; hold++) begin
            wait_cycle();
            compare_value("setup_done", 64'(setup_done), 64'd1);
        end
        compare_value("requests seen", 64'(req_seen - req_base), 64'(count));
        compare_value("mem_req_valid", 64'(mem_req_valid), 64'd0);
        descriptor_valid = 1'b0;
        hold = 0;
        while (setup_done !== 1'b0 && hold < 5) begin
            wait_cycle();
            hold++;
        end
        if (setup_done !== 1'b0) begin
            report_error("setup_done stayed high after the descriptor dropped");
        end
    endtask

    initial begin
        int          i;
        int          resp_base;
        logic [31:0] hi;
        descriptor_valid   = 1'b0;
        descriptor_pointer = '0;
        descriptor_count   = '0;
        mem_resp_in_valid  = 1'b0;
        mem_resp_in_data   = '0;
        req_random         = 1'b0;
        resp_random        = 1'b0;
        job_pointer        = '0;
        job_count          = 0;
        req_base           = 0;
        data_state         = SEED;
        checks             = 0;
        errors             = 0;
        tests_run          = 0;
        tests_failed       = 0;
        test_start_errors  = 0;

        wait (setup_areset === 1'b0);
        wait_cycle();

        compare_value("mem_req_valid", 64'(mem_req_valid), 64'd0);
        compare_value("mem_resp_valid", 64'(mem_resp_valid), 64'd0);
        compare_value("setup_done", 64'(setup_done), 64'd0);
        finish_test("outputs after reset");

        run_job(64'h0000_0001_0000_0000, JOB1_COUNT, 1'b0);
        finish_test("single job, free-flowing pops");

        run_job(64'h0000_0000_8000_0040, JOB2_COUNT, 1'b1);
        finish_test("back-pressure");

        run_job(64'h0000_00ab_cdef_0000, JOB3_COUNT, 1'b0);
        finish_test("done handshake and second job");

        run_job(64'h0000_0000_0004_0000, 0, 1'b0);
        finish_test("zero count");

        // Response path with random gaps and random pops
        resp_random = 1'b1;
        resp_base   = resp_seen;
        for (i = 0; i < RESP_COUNT; i++) begin
            data_state = xorshift32(data_state);
            hi         = data_state;
            data_state = xorshift32(data_state);
            mem_resp_in_data  = {hi, data_state};
            mem_resp_in_valid = 1'b1;
            resp_queue.push_back({hi, data_state});
            wait_cycle();
            mem_resp_in_valid = 1'b0;
            if (data_state[3]) begin
                wait_cycle();
            end
        end
        while (resp_seen - resp_base < RESP_COUNT) begin
            wait_cycle();
        end
        repeat (3) wait_cycle();
        compare_value("responses seen", 64'(resp_seen - resp_base), 64'(RESP_COUNT));
        compare_value("mem_resp_valid", 64'(mem_resp_valid), 64'd0);
        finish_test("response path");

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : glay_kernel_setup_tb

/* verification/tb_clock_gen.sv */
// Testbench clock and reset

`timescale 1ns/1ns

module tb_clock_gen (
    output logic ap_clk,
    output logic setup_areset
);
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 5;

    initial begin
        ap_clk = 1'b0;
        forever #HALF_PERIOD ap_clk = ~ap_clk;
    end

    // Released just after an edge, like every other input
    initial begin
        setup_areset = 1'b1;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        #1;
        setup_areset = 1'b0;
    end

endmodule : tb_clock_gen
